// File: all.f
nand_pkg.sv
nand_ifc.sv
fetch_unit.sv
rename_table.sv
decode_glue.sv
regfile.sv
exec_read_glue.sv
execute_unit.sv
nand_core.sv
tb_nand_core.sv

// File: Bender.yml
package:
  name: nand_core

sources:
  - nand_pkg.sv
  - nand_ifc.sv
  - fetch_unit.sv
  - rename_table.sv
  - decode_glue.sv
  - regfile.sv
  - exec_read_glue.sv
  - execute_unit.sv
  - nand_core.sv
  - target: simulation
    files:
      - tb_nand_core.sv

// File: tb_nand_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_nand_core;

typedef struct {
    logic is_branch;
    nand_pkg::pc_t pc;
    nand_pkg::areg_t areg;
    nand_pkg::data_t data;
    logic taken;
    nand_pkg::pc_t target;
} event_t;

logic clk;
logic rst_n;
logic wb_cyc;
logic wb_stb;
nand_pkg::pc_t wb_adr;
nand_pkg::data_t wb_dat_i;
logic wb_ack;
logic ret_valid;
nand_pkg::areg_t ret_reg;
nand_pkg::data_t ret_data;
nand_pkg::pc_t ret_pc;
logic br_valid;
nand_pkg::pc_t br_pc;
logic br_taken;
nand_pkg::pc_t br_target;

nand_pkg::data_t prog [$];      // instruction memory
string prog_test [$];           // test name per address
event_t exp_q [$];
int cycles = 0;
int cycle_limit = 0;
int value_errors = 0;
int event_errors = 0;
int timeouts = 0;

nand_core dut_i (
    .clk(clk),
    .rst_n(rst_n),
    .wb_cyc(wb_cyc),
    .wb_stb(wb_stb),
    .wb_adr(wb_adr),
    .wb_dat_i(wb_dat_i),
    .wb_ack(wb_ack),
    .ret_valid(ret_valid),
    .ret_reg(ret_reg),
    .ret_data(ret_data),
    .ret_pc(ret_pc),
    .br_valid(br_valid),
    .br_pc(br_pc),
    .br_taken(br_taken),
    .br_target(br_target)
);

initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
end

always @(posedge clk) cycles <= cycles + 1;

// ----------------------------------------------------------------------------
// program construction
// ----------------------------------------------------------------------------
function automatic nand_pkg::data_t reg_form(input nand_pkg::opcode_e op, input int rw,
                                             input int ra, input int rt);
    nand_pkg::instr_u w;
    w.r.opcode = op;
    w.r.rw = nand_pkg::areg_t'(rw);
    w.r.ra = nand_pkg::areg_t'(ra);
    w.r.rt = nand_pkg::areg_t'(rt);
    w.r.pad = '0;
    return w;
endfunction

function automatic nand_pkg::data_t imm_form(input nand_pkg::opcode_e op, input int rw,
                                             input int ra, input int imm);
    nand_pkg::instr_u w;
    w.i.opcode = op;
    w.i.rw = nand_pkg::areg_t'(rw);
    w.i.ra = nand_pkg::areg_t'(ra);
    w.i.immdt = nand_pkg::imm_t'(imm);
    return w;
endfunction

task automatic put_instr(input string test, input nand_pkg::data_t word);
    prog.push_back(word);
    prog_test.push_back(test);
endtask

task automatic build_program();
    put_instr("addi_add", imm_form(nand_pkg::OP_ADDI, 1, 0, 5));
    put_instr("addi_add", imm_form(nand_pkg::OP_ADDI, 2, 1, 7));    // back to back
    put_instr("addi_add", imm_form(nand_pkg::OP_ADDI, 3, 2, -3));
    put_instr("addi_add", reg_form(nand_pkg::OP_ADD, 4, 1, 2));
    put_instr("addi_add", reg_form(nand_pkg::OP_ADD, 5, 4, 3));
    put_instr("addi_add", imm_form(nand_pkg::OP_ADDI, 6, 5, 31));
    put_instr("addi_add", reg_form(nand_pkg::OP_ADD, 7, 6, 6));
    put_instr("addi_add", imm_form(nand_pkg::OP_ADDI, 0, 7, -32));
    put_instr("nand_eq", reg_form(nand_pkg::OP_NAND, 1, 7, 6));
    put_instr("nand_eq", reg_form(nand_pkg::OP_EQ, 2, 3, 3));      // equal
    put_instr("nand_eq", reg_form(nand_pkg::OP_EQ, 3, 4, 5));      // unequal
    put_instr("nand_eq", reg_form(nand_pkg::OP_NAND, 4, 2, 2));
    put_instr("bnz_not_taken", imm_form(nand_pkg::OP_BNZ, 0, 3, 5));
    put_instr("bnz_not_taken", imm_form(nand_pkg::OP_ADDI, 5, 5, 1));
    put_instr("bnz_taken", imm_form(nand_pkg::OP_BNZ, 0, 2, 2));
    put_instr("bnz_taken", imm_form(nand_pkg::OP_ADDI, 1, 0, 1));  // wrong path
    put_instr("bnz_taken", reg_form(nand_pkg::OP_ADD, 2, 2, 2));   // wrong path
    put_instr("bnz_taken", reg_form(nand_pkg::OP_ADD, 6, 1, 2));
    put_instr("loop", imm_form(nand_pkg::OP_ADDI, 7, 3, 12));      // iteration count
    put_instr("loop", imm_form(nand_pkg::OP_ADDI, 0, 3, 0));
    put_instr("loop", imm_form(nand_pkg::OP_ADDI, 0, 0, 3));       // loop head
    put_instr("loop", reg_form(nand_pkg::OP_ADD, 1, 1, 0));
    put_instr("loop", reg_form(nand_pkg::OP_NAND, 2, 1, 0));
    put_instr("loop", imm_form(nand_pkg::OP_ADDI, 7, 7, -1));
    put_instr("loop", imm_form(nand_pkg::OP_BNZ, 0, 7, -5));
    put_instr("loop", reg_form(nand_pkg::OP_EQ, 4, 7, 3));
    put_instr("loop", reg_form(nand_pkg::OP_ADD, 5, 0, 1));
endtask

function automatic nand_pkg::data_t read_word(input nand_pkg::pc_t adr);
    if (adr < prog.size())
        return prog[adr];
    return '0;  // nop
endfunction

function automatic string test_name(input nand_pkg::pc_t pc);
    if (pc < prog_test.size())
        return prog_test[pc];
    return "unknown";
endfunction

// ----------------------------------------------------------------------------
// architectural model, fills exp_q and returns the number of steps
// ----------------------------------------------------------------------------
function automatic int run_reference();
    nand_pkg::data_t regs [nand_pkg::NUM_AREG];
    nand_pkg::instr_u w;
    event_t ev;
    int pc;
    int off;
    int steps;
    for (int i = 0; i < nand_pkg::NUM_AREG; i++)
        regs[i] = '0;
    pc = 0;
    steps = 0;
    while (pc < prog.size() && steps < 2000) begin
        w = prog[pc];
        off = $signed(w.i.immdt);
        ev.is_branch = 1'b0;
        ev.pc = nand_pkg::pc_t'(pc);
        ev.areg = w.r.rw;
        ev.data = '0;
        ev.taken = 1'b0;
        ev.target = nand_pkg::pc_t'((pc + 1 + off) & ((1 << nand_pkg::PC_WIDTH) - 1));
        steps++;
        case (w.r.opcode)
            nand_pkg::OP_NAND: ev.data = ~(regs[w.r.ra] & regs[w.r.rt]);
            nand_pkg::OP_ADD: ev.data = regs[w.r.ra] + regs[w.r.rt];
            nand_pkg::OP_ADDI: ev.data = regs[w.r.ra] + nand_pkg::data_t'(off);
            nand_pkg::OP_EQ: ev.data = (regs[w.r.ra] == regs[w.r.rt]) ? 16'd1 : 16'd0;
            nand_pkg::OP_BNZ: begin
                ev.is_branch = 1'b1;
                ev.taken = regs[w.i.ra] != '0;
            end
            default: ;
        endcase
        if (ev.is_branch) begin
            exp_q.push_back(ev);
            pc = ev.taken ? int'(ev.target) : pc + 1;
        end else begin
            if (w.r.opcode != nand_pkg::OP_NOP) begin
                regs[w.r.rw] = ev.data;
                exp_q.push_back(ev);
            end
            pc = pc + 1;
        end
    end
    return steps;
endfunction

// ----------------------------------------------------------------------------
// result checks
// ----------------------------------------------------------------------------
task automatic check_retire(input string test, input nand_pkg::areg_t exp_reg,
                            input nand_pkg::data_t exp_data, input nand_pkg::pc_t exp_pc,
                            input nand_pkg::areg_t act_reg, input nand_pkg::data_t act_data,
                            input nand_pkg::pc_t act_pc);
    if (act_pc !== exp_pc) begin
        $display("ERR %s retire pc: expected %0d actual %0d", test, exp_pc, act_pc);
        value_errors++;
    end
    if (act_reg !== exp_reg) begin
        $display("ERR %s retire reg at pc %0d: expected r%0d actual r%0d",
                 test, exp_pc, exp_reg, act_reg);
        value_errors++;
    end
    if (act_data !== exp_data) begin
        $display("ERR %s retire data at pc %0d: expected %h actual %h",
                 test, exp_pc, exp_data, act_data);
        value_errors++;
    end
endtask

task automatic check_branch(input string test, input nand_pkg::pc_t exp_pc,
                            input logic exp_taken, input nand_pkg::pc_t exp_target,
                            input nand_pkg::pc_t act_pc, input logic act_taken,
                            input nand_pkg::pc_t act_target);
    if (act_pc !== exp_pc) begin
        $display("ERR %s branch pc: expected %0d actual %0d", test, exp_pc, act_pc);
        value_errors++;
    end
    if (act_taken !== exp_taken) begin
        $display("ERR %s branch taken at pc %0d: expected %b actual %b",
                 test, exp_pc, exp_taken, act_taken);
        value_errors++;
    end
    if (act_target !== exp_target) begin
        $display("ERR %s branch target at pc %0d: expected %0d actual %0d",
                 test, exp_pc, exp_target, act_target);
        value_errors++;
    end
endtask

// wishbone slave, ack after 0 to 3 wait cycles
initial begin : wishbone_memory
    int wait_cnt;
    logic busy;
    wb_ack = 1'b0;
    wb_dat_i = '0;
    busy = 1'b0;
    wait_cnt = 0;
    void'($urandom(29));
    forever begin
        @(posedge clk);
        if (wb_ack) begin
            wb_ack <= 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!busy) begin
                busy = 1'b1;
                wait_cnt = $urandom % 4;
            end
            if (wait_cnt == 0) begin
                wb_ack <= 1'b1;
                wb_dat_i <= read_word(wb_adr);
                busy = 1'b0;
            end else begin
                wait_cnt = wait_cnt - 1;
            end
        end
    end
end

always @(negedge clk) begin : compare_events
    event_t ev;
    if (rst_n === 1'b1 && (ret_valid === 1'b1 || br_valid === 1'b1)) begin
        if (exp_q.size() == 0) begin
            $display("an event at pc %0d arrived after all expected events were seen",
                     ret_valid ? ret_pc : br_pc);
            event_errors++;
        end else begin
            ev = exp_q.pop_front();
            if (ret_valid === 1'b1 && !ev.is_branch) begin
                check_retire(test_name(ev.pc), ev.areg, ev.data, ev.pc,
                             ret_reg, ret_data, ret_pc);
            end else if (br_valid === 1'b1 && ev.is_branch) begin
                check_branch(test_name(ev.pc), ev.pc, ev.taken, ev.target,
                             br_pc, br_taken, br_target);
            end else begin
                $display("the DUT reported the wrong kind of event at pc %0d, expected %s at pc %0d",
                         ret_valid ? ret_pc : br_pc, ev.is_branch ? "a branch" : "a retire",
                         ev.pc);
                event_errors++;
            end
        end
    end
end

initial begin : main
    int steps;
    rst_n = 1'b0;
    build_program();
    steps = run_reference();
    cycle_limit = steps * 8 + 50;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    while (exp_q.size() != 0 && cycles < cycle_limit)
        @(posedge clk);
    if (exp_q.size() != 0) begin
        $display("timeout after %0d cycles with %0d expected events still missing",
                 cycles, exp_q.size());
        foreach (exp_q[i])
            $display("no %s seen for pc %0d in test %s",
                     exp_q[i].is_branch ? "branch" : "retire", exp_q[i].pc,
                     test_name(exp_q[i].pc));
        timeouts++;
    end
    repeat (30) @(posedge clk);  // catch stray events

    $display("errors: %0d value, %0d event, %0d timeout",
             value_errors, event_errors, timeouts);
    if (value_errors == 0 && event_errors == 0 && timeouts == 0) begin
        $display("Everything OK");
    end else begin
        $display("Something failed");
    end
    $finish;
end

endmodule

`default_nettype wire

// File: nand_core.sv
`timescale 1ns/10ps
`default_nettype none

module nand_core
(
    input logic clk,
    input logic rst_n,

    output logic wb_cyc,
    output logic wb_stb,
    output nand_pkg::pc_t wb_adr,
    input nand_pkg::data_t wb_dat_i,
    input logic wb_ack,

    output logic ret_valid,
    output nand_pkg::areg_t ret_reg,
    output nand_pkg::data_t ret_data,
    output nand_pkg::pc_t ret_pc,
    output logic br_valid,
    output nand_pkg::pc_t br_pc,
    output logic br_taken,
    output nand_pkg::pc_t br_target
);

logic flush;
nand_pkg::pc_t redirect_pc;

fetch_ifc fetch_if ();
rename_ifc ren_if ();
exec_buffer_ifc eb_dec ();  // decode to read
exec_buffer_ifc eb_exe ();  // read to execute
retire_ifc ret_if ();

fetch_unit fetch_unit_i (
    .clk(clk),
    .rst_n(rst_n),
    .wb_cyc(wb_cyc),
    .wb_stb(wb_stb),
    .wb_adr(wb_adr),
    .wb_dat_i(wb_dat_i),
    .wb_ack(wb_ack),
    .flush(flush),
    .redirect_pc(redirect_pc),
    .fetch(fetch_if.out)
);

rename_table rename_table_i (
    .clk(clk),
    .rst_n(rst_n),
    .ren(ren_if.tbl),
    .ret(ret_if.tbl),
    .flush(flush)
);

decode_glue decode_glue_i (
    .clk(clk),
    .rst_n(rst_n),
    .fetch(fetch_if.in),
    .ren(ren_if.other),
    .flush(flush),
    .eb(eb_dec.out)
);

exec_read_glue exec_read_glue_i (
    .clk(clk),
    .rst_n(rst_n),
    .eb_in(eb_dec.in),
    .ret(ret_if.tbl),
    .flush(flush),
    .eb_out(eb_exe.out)
);

execute_unit execute_unit_i (
    .clk(clk),
    .rst_n(rst_n),
    .eb(eb_exe.in),
    .ret(ret_if.write),
    .flush(flush),
    .redirect_pc(redirect_pc),
    .ret_valid(ret_valid),
    .ret_reg(ret_reg),
    .ret_data(ret_data),
    .ret_pc(ret_pc),
    .br_valid(br_valid),
    .br_pc(br_pc),
    .br_taken(br_taken),
    .br_target(br_target)
);

endmodule

`default_nettype wire

// File: execute_unit.sv
`timescale 1ns/10ps
`default_nettype none

module execute_unit
(
    input logic clk,
    input logic rst_n,

    exec_buffer_ifc.in eb,
    retire_ifc.write ret,

    output logic flush,
    output nand_pkg::pc_t redirect_pc,

    output logic ret_valid,
    output nand_pkg::areg_t ret_reg,
    output nand_pkg::data_t ret_data,
    output nand_pkg::pc_t ret_pc,
    output logic br_valid,
    output nand_pkg::pc_t br_pc,
    output logic br_taken,
    output nand_pkg::pc_t br_target
);

nand_pkg::data_t result;
logic br_now;       // a branch resolves this cycle
logic taken;
nand_pkg::pc_t target;

// ---------------------------------------------------------------------------
// ALU and branch resolution
// ---------------------------------------------------------------------------
always_comb begin
    case (eb.alu_op)
        nand_pkg::ALU_NAND: result = ~(eb.op0 & eb.op1);
        nand_pkg::ALU_ADD: result = eb.op0 + eb.op1;
        nand_pkg::ALU_EQ: result = {{(nand_pkg::DATA_WIDTH - 1){1'b0}}, eb.op0 == eb.op1};
        default: result = '0;
    endcase

    // anything here while flush is high is younger than the branch
    br_now = eb.valid & eb.is_branch & ~flush;
    taken = eb.op0 != '0;
    target = eb.pc + 1'b1 +
        {{(nand_pkg::PC_WIDTH - nand_pkg::IMM_WIDTH){eb.immdt[nand_pkg::IMM_WIDTH-1]}},
         eb.immdt};

    ret.valid = eb.valid & eb.writes & ~flush;
    ret.areg = eb.areg_rw;
    ret.preg = eb.preg_rw;
    ret.preg_prev = eb.preg_prev;
    ret.preg_data = result;
end

// ---------------------------------------------------------------------------
// registered outputs
// ---------------------------------------------------------------------------
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        ret_valid <= 1'b0;
        br_valid <= 1'b0;
        flush <= 1'b0;
    end else begin
        ret_valid <= ret.valid;
        br_valid <= br_now;
        flush <= br_now & taken;    // predicted not taken, so taken is a miss
    end
end

always_ff @(posedge clk) begin
    ret_reg <= eb.areg_rw;
    ret_data <= result;
    ret_pc <= eb.pc;
    br_pc <= eb.pc;
    br_taken <= taken;
    br_target <= target;
    redirect_pc <= target;
end

// the read stage has to drop whatever followed the branch
a_flush_drops_younger: assert property (@(posedge clk) disable iff (!rst_n)
    flush |=> !eb.valid);

endmodule

`default_nettype wire

// File: exec_read_glue.sv
`timescale 1ns/10ps
`default_nettype none

module exec_read_glue
(
    input logic clk,
    input logic rst_n,

    exec_buffer_ifc.in eb_in,
    retire_ifc.tbl ret,

    input logic flush,

    exec_buffer_ifc.out eb_out
);

nand_pkg::data_t ra_data;
nand_pkg::data_t rt_data;
nand_pkg::data_t op0;
nand_pkg::data_t op1;
nand_pkg::data_t rt_val;

regfile regfile_i (
    .clk(clk),
    .rst_n(rst_n),
    .ra_addr(eb_in.preg_ra),
    .rt_addr(eb_in.preg_rt),
    .ra_data(ra_data),
    .rt_data(rt_data),
    .ret(ret)
);

always_comb begin
    // the result being retired this cycle is not in the file yet
    op0 = (ret.valid && ret.preg == eb_in.preg_ra) ? ret.preg_data : ra_data;
    rt_val = (ret.valid && ret.preg == eb_in.preg_rt) ? ret.preg_data : rt_data;
    op1 = eb_in.use_rt ? rt_val :
        {{(nand_pkg::DATA_WIDTH - nand_pkg::IMM_WIDTH){eb_in.immdt[nand_pkg::IMM_WIDTH-1]}},
         eb_in.immdt};
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
        eb_out.valid <= 1'b0;
    else
        eb_out.valid <= eb_in.valid & ~flush;
end

always_ff @(posedge clk) begin
    if (eb_in.valid) begin
        eb_out.pc <= eb_in.pc;
        eb_out.alu_op <= eb_in.alu_op;
        eb_out.is_branch <= eb_in.is_branch;
        eb_out.writes <= eb_in.writes;
        eb_out.immdt <= eb_in.immdt;
        eb_out.areg_rw <= eb_in.areg_rw;
        eb_out.preg_rw <= eb_in.preg_rw;
        eb_out.preg_prev <= eb_in.preg_prev;
        eb_out.op0 <= op0;
        eb_out.op1 <= op1;
    end
end

endmodule

`default_nettype wire

// File: regfile.sv
`timescale 1ns/10ps
`default_nettype none

module regfile
(
    input logic clk,
    input logic rst_n,

    input nand_pkg::preg_t ra_addr,
    input nand_pkg::preg_t rt_addr,
    output nand_pkg::data_t ra_data,
    output nand_pkg::data_t rt_data,

    retire_ifc.tbl ret
);

nand_pkg::data_t regs [nand_pkg::NUM_PREG];

// reads are combinational, the read stage bypasses same-cycle writes
assign ra_data = regs[ra_addr];
assign rt_data = regs[rt_addr];

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        for (int i = 0; i < nand_pkg::NUM_PREG; i++) begin
            regs[i] <= '0;
        end
    end else if (ret.valid) begin
        regs[ret.preg] <= ret.preg_data;
    end
end

endmodule

`default_nettype wire

// File: decode_glue.sv
`timescale 1ns/10ps
`default_nettype none

module decode_glue
(
    input logic clk,
    input logic rst_n,

    fetch_ifc.in fetch,
    rename_ifc.other ren,

    input logic flush,

    exec_buffer_ifc.out eb
);

nand_pkg::alu_op_e alu_op;
logic writes;
logic use_rt;
logic is_branch;
logic known;    // decodes to something that executes

always_comb begin
    alu_op = nand_pkg::ALU_ADD;
    writes = 1'b1;
    use_rt = 1'b1;
    is_branch = 1'b0;
    known = 1'b1;
    case (fetch.instr.r.opcode)
        nand_pkg::OP_NAND: alu_op = nand_pkg::ALU_NAND;
        nand_pkg::OP_ADD: alu_op = nand_pkg::ALU_ADD;
        nand_pkg::OP_ADDI: use_rt = 1'b0;
        nand_pkg::OP_EQ: alu_op = nand_pkg::ALU_EQ;
        nand_pkg::OP_BNZ: begin
            writes = 1'b0;
            use_rt = 1'b0;
            is_branch = 1'b1;
        end
        default: begin  // nop and spare encodings
            writes = 1'b0;
            known = 1'b0;
        end
    endcase

    ren.areg_ra = fetch.instr.r.ra;
    ren.areg_rt = fetch.instr.r.rt;
    ren.areg_rw = fetch.instr.i.rw;
    ren.alloc = fetch.valid & writes & ~flush;
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
        eb.valid <= 1'b0;
    else
        eb.valid <= fetch.valid & known & ~flush;
end

always_ff @(posedge clk) begin
    if (fetch.valid) begin
        eb.pc <= fetch.pc;
        eb.alu_op <= alu_op;
        eb.is_branch <= is_branch;
        eb.writes <= writes;
        eb.use_rt <= use_rt;
        eb.immdt <= fetch.instr.i.immdt;
        eb.areg_rw <= fetch.instr.i.rw;
        eb.preg_ra <= ren.preg_ra;
        eb.preg_rt <= ren.preg_rt;
        eb.preg_rw <= ren.preg_new;
        eb.preg_prev <= ren.preg_prev;
    end
end

endmodule

`default_nettype wire

// File: rename_table.sv
`timescale 1ns/10ps
`default_nettype none

module rename_table
(
    input logic clk,
    input logic rst_n,

    rename_ifc.tbl ren,
    retire_ifc.tbl ret,

    input logic flush
);

nand_pkg::preg_t spec_map [nand_pkg::NUM_AREG];
nand_pkg::preg_t arch_map [nand_pkg::NUM_AREG];
logic [nand_pkg::NUM_PREG-1:0] free_vec;
logic [nand_pkg::NUM_PREG-1:0] free_next;

// ---------------------------------------------------------------------------
// lookup and allocation
// ---------------------------------------------------------------------------
always_comb begin
    ren.preg_ra = spec_map[ren.areg_ra];
    ren.preg_rt = spec_map[ren.areg_rt];
    ren.preg_prev = spec_map[ren.areg_rw];

    ren.preg_new = '0;
    for (int i = nand_pkg::NUM_PREG - 1; i >= 0; i--) begin
        if (free_vec[i])
            ren.preg_new = nand_pkg::preg_t'(i);    // lowest free wins
    end
end

always_comb begin
    free_next = free_vec;
    if (flush) begin
        // everything the committed state does not name is free again
        free_next = '1;
        for (int i = 0; i < nand_pkg::NUM_AREG; i++) begin
            free_next[arch_map[i]] = 1'b0;
        end
    end else begin
        if (ren.alloc)
            free_next[ren.preg_new] = 1'b0;
        if (ret.valid)
            free_next[ret.preg_prev] = 1'b1;
    end
end

// ---------------------------------------------------------------------------
// state update
// ---------------------------------------------------------------------------
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        for (int i = 0; i < nand_pkg::NUM_AREG; i++) begin
            spec_map[i] <= nand_pkg::preg_t'(i);
            arch_map[i] <= nand_pkg::preg_t'(i);
        end
        free_vec <= {{(nand_pkg::NUM_PREG - nand_pkg::NUM_AREG){1'b1}},
                     {nand_pkg::NUM_AREG{1'b0}}};
    end else begin
        free_vec <= free_next;
        if (ret.valid)
            arch_map[ret.areg] <= ret.preg;
        if (flush)
            spec_map <= arch_map;   // recovery to committed state
        else if (ren.alloc)
            spec_map[ren.areg_rw] <= ren.preg_new;
    end
end

a_alloc_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
    ren.alloc |-> free_vec != '0);

endmodule

`default_nettype wire

// File: fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_unit
(
    input logic clk,
    input logic rst_n,

    output logic wb_cyc,
    output logic wb_stb,
    output nand_pkg::pc_t wb_adr,
    input nand_pkg::data_t wb_dat_i,
    input logic wb_ack,

    input logic flush,
    input nand_pkg::pc_t redirect_pc,

    fetch_ifc.out fetch
);

nand_pkg::pc_t pc;      // next address to request
logic discard;          // outstanding word belongs to a flushed path

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        pc <= '0;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_adr <= '0;
        discard <= 1'b0;
        fetch.valid <= 1'b0;
    end else begin
        fetch.valid <= 1'b0;
        if (flush)
            pc <= redirect_pc;
        if (wb_cyc) begin
            if (wb_ack) begin
                wb_cyc <= 1'b0;     // one idle cycle between reads
                wb_stb <= 1'b0;
                discard <= 1'b0;
                if (!flush && !discard) begin
                    fetch.valid <= 1'b1;
                    pc <= pc + 1'b1;
                end
            end else if (flush) begin
                discard <= 1'b1;
            end
        end else begin
            wb_cyc <= 1'b1;
            wb_stb <= 1'b1;
            wb_adr <= flush ? redirect_pc : pc;
        end
    end
end

always_ff @(posedge clk) begin
    if (wb_cyc && wb_ack) begin
        fetch.instr <= wb_dat_i;
        fetch.pc <= wb_adr;
    end
end

a_stb_needs_cyc: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(wb_stb) |-> wb_cyc);

endmodule

`default_nettype wire

// File: nand_ifc.sv
`timescale 1ns/10ps
`default_nettype none

interface fetch_ifc;
logic valid;    // one pulse per fetched word
nand_pkg::pc_t pc;
nand_pkg::instr_u instr;

modport out (output valid, pc, instr);
modport in (input valid, pc, instr);
endinterface

interface rename_ifc;
logic alloc;
nand_pkg::areg_t areg_ra;
nand_pkg::areg_t areg_rt;
nand_pkg::areg_t areg_rw;
nand_pkg::preg_t preg_ra;
nand_pkg::preg_t preg_rt;
nand_pkg::preg_t preg_new;
nand_pkg::preg_t preg_prev;     // old mapping of areg_rw

modport other (
    output alloc, areg_ra, areg_rt, areg_rw,
    input preg_ra, preg_rt, preg_new, preg_prev
);
modport tbl (
    input alloc, areg_ra, areg_rt, areg_rw,
    output preg_ra, preg_rt, preg_new, preg_prev
);
endinterface

// preg_ra/preg_rt matter before the read stage, op0/op1 after it
interface exec_buffer_ifc;
logic valid;
nand_pkg::pc_t pc;
nand_pkg::alu_op_e alu_op;
logic is_branch;
logic writes;
logic use_rt;
nand_pkg::imm_t immdt;
nand_pkg::areg_t areg_rw;
nand_pkg::preg_t preg_ra;
nand_pkg::preg_t preg_rt;
nand_pkg::preg_t preg_rw;
nand_pkg::preg_t preg_prev;
nand_pkg::data_t op0;
nand_pkg::data_t op1;

modport out (
    output valid, pc, alu_op, is_branch, writes, use_rt, immdt, areg_rw,
        preg_ra, preg_rt, preg_rw, preg_prev, op0, op1
);
modport in (
    input valid, pc, alu_op, is_branch, writes, use_rt, immdt, areg_rw,
        preg_ra, preg_rt, preg_rw, preg_prev, op0, op1
);
endinterface

interface retire_ifc;
logic valid;
nand_pkg::areg_t areg;
nand_pkg::preg_t preg;
nand_pkg::preg_t preg_prev;     // freed once this result commits
nand_pkg::data_t preg_data;

modport write (output valid, areg, preg, preg_prev, preg_data);
modport tbl (input valid, areg, preg, preg_prev, preg_data);
endinterface

`default_nettype wire

// File: nand_pkg.sv
`default_nettype none

package nand_pkg;

// ---------------------------------------------------------------------------
// widths and sizes
// ---------------------------------------------------------------------------
localparam int DATA_WIDTH = 16;
localparam int PC_WIDTH = 8;
localparam int IMM_WIDTH = 6;
localparam int NUM_AREG = 8;
localparam int NUM_PREG = 16;

typedef logic [DATA_WIDTH-1:0] data_t;
typedef logic [PC_WIDTH-1:0] pc_t;
typedef logic [$clog2(NUM_AREG)-1:0] areg_t;
typedef logic [$clog2(NUM_PREG)-1:0] preg_t;
typedef logic [IMM_WIDTH-1:0] imm_t;    // signed, sign-extended where used

// ---------------------------------------------------------------------------
// instruction encoding
// ---------------------------------------------------------------------------
typedef enum logic [3:0] {
    OP_NOP  = 4'd0,
    OP_NAND = 4'd1,
    OP_ADD  = 4'd2,
    OP_ADDI = 4'd3,
    OP_EQ   = 4'd4,
    OP_BNZ  = 4'd5
} opcode_e;

typedef enum logic [1:0] {
    ALU_NAND = 2'd0,
    ALU_ADD  = 2'd1,
    ALU_EQ   = 2'd2
} alu_op_e;

// three register operands
typedef struct packed {
    opcode_e opcode;
    areg_t rw;
    areg_t ra;
    areg_t rt;
    logic [2:0] pad;
} instr_reg_t;

// register plus immediate, bnz uses ra as the tested register
typedef struct packed {
    opcode_e opcode;
    areg_t rw;
    areg_t ra;
    imm_t immdt;
} instr_imm_t;

typedef union packed {
    instr_reg_t r;
    instr_imm_t i;
} instr_u;

endpackage

`default_nettype wire
